// File: Bender.yml
package:
  name: gidx_sched

sources:
  - common/gidx_pkg.sv
  - verilog/gidx_ctrl.sv
  - gidx_sched/gidx_lookahead.sv
  - gidx_sched/gidx_slot_table.sv
  - gidx_sched/gidx_order_queue.sv
  - verilog/gidx_sched_top.sv
  - target: simulation
    files:
      - verification/gidx_sched_chk.sv
      - verification/gidx_sched_tb.sv

// File: common/gidx_pkg.sv
// Group-index scheduler package with sizes and state encodings

package gidx_pkg;

  // Vector and slot geometry
  localparam int unsigned NUM_ROWS  = 8;
  localparam int unsigned NUM_SLOTS = 2;
  localparam int unsigned GID_W     = 3;
  localparam int unsigned ROW_W     = 3;
  localparam int unsigned SLOT_W    = 1;

  // Candidate list holds the cached slot indices first, then the vector entries
  localparam int unsigned CAND_NUM = NUM_SLOTS + NUM_ROWS;
  localparam int unsigned CAND_W   = $clog2(CAND_NUM);

  // Group record queue
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int unsigned QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  // Pending rows per slot, worst case every queued record on one slot
  localparam int unsigned CNT_W = $clog2(NUM_ROWS * QUEUE_DEPTH + 1);

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    ACK
  } ctrl_state_e;

  // Outcome of one lookahead step
  typedef enum logic [1:0] {
    SKIP,   // no unmatched row shares the candidate
    GROUP,  // a record is pushed
    STALL,  // queue full or no slot available
    LAST    // vector fully matched or list exhausted
  } scan_res_e;

endpackage

// File: gidx_sched/gidx_lookahead.sv
// Lookahead scanner that walks the candidate list and builds group match masks

module gidx_lookahead
  import gidx_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            scan_en_i,
  input  logic                            scan_start_i,
  input  logic [NUM_ROWS-1:0][GID_W-1:0]  vec_i,
  input  logic [NUM_SLOTS-1:0][GID_W-1:0] slot_gidx_i,
  input  logic [NUM_SLOTS-1:0]            slot_valid_i,
  input  logic                            queue_full_i,
  input  logic                            slot_ok_i,
  input  logic                            hit_i,
  output scan_res_e                       scan_res_o,
  output logic                            grp_push_o,
  output logic [GID_W-1:0]                grp_gidx_o,
  output logic [NUM_ROWS-1:0]             grp_mask_o,
  output logic                            grp_load_o
);

  logic [CAND_NUM-1:0][GID_W-1:0] cand;
  logic [CAND_W-1:0]              offset_d, offset_q;
  logic [NUM_ROWS-1:0]            unmatched_q, unmatched_next, match;
  logic                           cand_valid, has_match;
  logic                           stall, step, done;

  // Cached slot indices sit at the low end of the list
  assign cand = {vec_i, slot_gidx_i};

  assign cand_valid = (offset_q < CAND_W'(NUM_SLOTS)) ?
                      slot_valid_i[offset_q[SLOT_W-1:0]] : 1'b1;
  assign grp_gidx_o = cand[offset_q];

  always_comb begin
    for (int i = 0; i < NUM_ROWS; i++) begin
      match[i] = cand_valid && unmatched_q[i] && (vec_i[i] == grp_gidx_o);
    end
  end

  assign has_match      = |match;
  assign unmatched_next = unmatched_q & ~match;

  // A group needs both a queue entry and a scale slot
  assign stall = scan_en_i && has_match && (queue_full_i || !slot_ok_i);
  assign step  = scan_en_i && !stall;
  assign done  = step && ((offset_q == CAND_W'(CAND_NUM - 1)) || (unmatched_next == '0));

  assign grp_push_o = step && has_match;
  assign grp_mask_o = match;
  assign grp_load_o = !hit_i;

  always_comb begin
    if (!scan_en_i) begin
      scan_res_o = SKIP;
    end else if (stall) begin
      scan_res_o = STALL;
    end else if (done) begin
      scan_res_o = LAST;
    end else if (has_match) begin
      scan_res_o = GROUP;
    end else begin
      scan_res_o = SKIP;
    end
  end

  // Later vectors start at 0 so the cached indices are tried first
  always_comb begin
    offset_d = offset_q;
    if (step) begin
      offset_d = done ? '0 : offset_q + CAND_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q    <= CAND_W'(NUM_SLOTS);
      unmatched_q <= '1;
    end else if (clear_i) begin
      offset_q    <= CAND_W'(NUM_SLOTS);
      unmatched_q <= '1;
    end else begin
      offset_q <= offset_d;
      if (scan_start_i) begin
        unmatched_q <= '1;
      end else if (step) begin
        unmatched_q <= unmatched_next;
      end
    end
  end

endmodule

// File: gidx_sched/gidx_order_queue.sv
// Group record queue that expands each record into ordered single-row outputs

module gidx_order_queue
  import gidx_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                grp_push_i,
  input  logic [GID_W-1:0]    grp_gidx_i,
  input  logic [NUM_ROWS-1:0] grp_mask_i,
  input  logic                grp_load_i,
  input  logic [SLOT_W-1:0]   grp_slot_i,
  output logic                queue_full_o,
  input  logic                out_ready_i,
  output logic                out_valid_o,
  output logic [GID_W-1:0]    out_gidx_o,
  output logic [ROW_W-1:0]    out_row_o,
  output logic [SLOT_W-1:0]   out_slot_o,
  output logic                out_load_o,
  output logic                row_done_o,
  output logic [SLOT_W-1:0]   row_slot_o
);

  logic [QUEUE_DEPTH-1:0][GID_W-1:0]    gidx_mem;
  logic [QUEUE_DEPTH-1:0][NUM_ROWS-1:0] mask_mem;
  logic [QUEUE_DEPTH-1:0]               load_mem;
  logic [QUEUE_DEPTH-1:0][SLOT_W-1:0]   slot_mem;

  logic [QPTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [QCNT_W-1:0]   count_q;
  logic [NUM_ROWS-1:0] order_q, remain, row_bit;
  logic                first_q, xfer, pop;

  always_ff @(posedge clk_i) begin
    if (grp_push_i) begin
      gidx_mem[wr_ptr_q] <= grp_gidx_i;
      mask_mem[wr_ptr_q] <= grp_mask_i;
      load_mem[wr_ptr_q] <= grp_load_i;
      slot_mem[wr_ptr_q] <= grp_slot_i;
    end
  end

  // Rows of the head record not yet sent
  assign remain = mask_mem[rd_ptr_q] & order_q;

  always_comb begin
    out_row_o = '0;
    for (int i = NUM_ROWS - 1; i >= 0; i--) begin
      if (remain[i]) begin
        out_row_o = ROW_W'(i);
      end
    end
  end

  assign row_bit      = NUM_ROWS'(1) << out_row_o;
  assign out_valid_o  = (count_q != '0);
  assign xfer         = out_valid_o && out_ready_i;
  assign pop          = xfer && ((remain & ~row_bit) == '0);
  assign queue_full_o = (count_q == QCNT_W'(QUEUE_DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      order_q  <= '1;
      first_q  <= 1'b1;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      order_q  <= '1;
      first_q  <= 1'b1;
    end else begin
      if (grp_push_i) begin
        wr_ptr_q <= wr_ptr_q + QPTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + QPTR_W'(1);
        order_q  <= '1;
        first_q  <= 1'b1;
      end else if (xfer) begin
        order_q <= order_q & ~row_bit;
        first_q <= 1'b0;
      end
      if (grp_push_i && !pop) begin
        count_q <= count_q + QCNT_W'(1);
      end else if (pop && !grp_push_i) begin
        count_q <= count_q - QCNT_W'(1);
      end
    end
  end

  assign out_gidx_o = gidx_mem[rd_ptr_q];
  assign out_slot_o = slot_mem[rd_ptr_q];
  // Scale fetch is requested once per record
  assign out_load_o = out_valid_o && first_q && load_mem[rd_ptr_q];
  assign row_done_o = xfer;
  assign row_slot_o = slot_mem[rd_ptr_q];

endmodule

// File: gidx_sched/gidx_slot_table.sv
// Scale slot table with presence lookup, slot allocation and pending-row counters

module gidx_slot_table
  import gidx_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic [GID_W-1:0]                cand_gidx_i,
  input  logic                            grp_push_i,
  input  logic [NUM_ROWS-1:0]             grp_mask_i,
  input  logic                            row_done_i,
  input  logic [SLOT_W-1:0]               row_slot_i,
  output logic [NUM_SLOTS-1:0][GID_W-1:0] slot_gidx_o,
  output logic [NUM_SLOTS-1:0]            slot_valid_o,
  output logic                            hit_o,
  output logic [SLOT_W-1:0]               slot_o,
  output logic                            slot_ok_o
);

  logic [NUM_SLOTS-1:0][GID_W-1:0] gidx_q;
  logic [NUM_SLOTS-1:0]            valid_q;
  logic [NUM_SLOTS-1:0][CNT_W-1:0] cnt_q;
  logic [SLOT_W-1:0]               hit_slot, inv_slot, idle_slot;
  logic                            inv_found, idle_found;
  logic [CNT_W-1:0]                grp_cnt;

  // Descending loops leave the lowest qualifying slot selected
  always_comb begin
    hit_o      = 1'b0;
    hit_slot   = '0;
    inv_found  = 1'b0;
    inv_slot   = '0;
    idle_found = 1'b0;
    idle_slot  = '0;
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
      if (valid_q[s] && (gidx_q[s] == cand_gidx_i)) begin
        hit_o    = 1'b1;
        hit_slot = SLOT_W'(s);
      end
      if (!valid_q[s]) begin
        inv_found = 1'b1;
        inv_slot  = SLOT_W'(s);
      end
      if (cnt_q[s] == '0) begin
        idle_found = 1'b1;
        idle_slot  = SLOT_W'(s);
      end
    end
  end

  assign slot_o    = hit_o ? hit_slot : (inv_found ? inv_slot : idle_slot);
  assign slot_ok_o = hit_o || inv_found || idle_found;

  // Number of rows carried by the pushed record
  always_comb begin
    grp_cnt = '0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      grp_cnt = grp_cnt + CNT_W'(grp_mask_i[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gidx_q  <= '0;
      valid_q <= '0;
      cnt_q   <= '0;
    end else if (clear_i) begin
      gidx_q  <= '0;
      valid_q <= '0;
      cnt_q   <= '0;
    end else begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (grp_push_i && (slot_o == SLOT_W'(s))) begin
          if (hit_o) begin
            cnt_q[s] <= cnt_q[s] + grp_cnt -
                        CNT_W'(row_done_i && (row_slot_i == SLOT_W'(s)));
          end else begin
            // A reallocated slot has no rows left in flight
            gidx_q[s]  <= cand_gidx_i;
            valid_q[s] <= 1'b1;
            cnt_q[s]   <= grp_cnt;
          end
        end else if (row_done_i && (row_slot_i == SLOT_W'(s))) begin
          cnt_q[s] <= cnt_q[s] - CNT_W'(1);
        end
      end
    end
  end

  assign slot_gidx_o  = gidx_q;
  assign slot_valid_o = valid_q;

endmodule

// File: verification/gidx_sched_chk.sv
// Bound checker for the vector handshake, output stability and reset state

module gidx_sched_chk
  import gidx_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              clear_i,
  input logic              vec_req_i,
  input logic              vec_ack_o,
  input logic              out_ready_i,
  input logic              out_valid_o,
  input logic [GID_W-1:0]  out_gidx_o,
  input logic [ROW_W-1:0]  out_row_o,
  input logic [SLOT_W-1:0] out_slot_o,
  input logic              out_load_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // Acknowledge only answers a live request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(vec_ack_o) |-> vec_req_i)
    else begin
      fail_cnt++;
      $error("Acknowledge rose while the request was low");
    end

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    vec_req_i && !vec_ack_o |=> vec_req_i)
    else begin
      fail_cnt++;
      $error("Request dropped before the acknowledge rose");
    end

  ack_falls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(vec_req_i) |-> ##[0:1] !vec_ack_o)
    else begin
      fail_cnt++;
      $error("Acknowledge stayed high after the request fell");
    end

  // Stalled output holds every field
  out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_gidx_o) &&
      $stable(out_row_o) && $stable(out_slot_o) && $stable(out_load_o))
    else begin
      fail_cnt++;
      $error("Output changed while stalled by ready");
    end

  reset_low: assert property (@(posedge clk_i)
    !rst_ni || $rose(rst_ni) |-> !vec_ack_o && !out_valid_o && !out_load_o)
    else begin
      fail_cnt++;
      $error("Outputs not low around reset");
    end

endmodule

// File: verification/gidx_sched_tb.sv
// Testbench for the group-index scheduler with random vectors, back-pressure and slot checks

module gidx_sched_tb
  import gidx_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NUM_VEC    = 30;
  localparam int unsigned CLEAR_VEC  = 15;
  localparam int unsigned MAX_CYCLES = NUM_VEC * (CAND_NUM + 4 * NUM_ROWS) + 400;

  logic                           clk, rst_n, clear;
  logic                           vec_req, vec_ack;
  logic [NUM_ROWS-1:0][GID_W-1:0] vec_gidx;
  logic                           out_ready, out_valid, out_load;
  logic [GID_W-1:0]               out_gidx;
  logic [ROW_W-1:0]               out_row;
  logic [SLOT_W-1:0]              out_slot;

  int unsigned                    lcg_state = 32'd5485;
  int unsigned                    err_cnt;
  int unsigned                    cycle_cnt;
  logic [NUM_ROWS-1:0][GID_W-1:0] vectors [NUM_VEC];

  // Rows observed on the output port for the vector in flight
  logic [GID_W-1:0]  seen_gidx [$];
  logic [ROW_W-1:0]  seen_row  [$];
  logic [SLOT_W-1:0] seen_slot [$];
  logic              seen_load [$];

  // Slot contents as far as the emitted load flags reveal them
  logic [NUM_SLOTS-1:0][GID_W-1:0] shadow_gidx;
  logic [NUM_SLOTS-1:0]            shadow_valid;
  logic                            after_clear;

  gidx_sched_top i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .clear_i     (clear),
    .vec_req_i   (vec_req),
    .vec_gidx_i  (vec_gidx),
    .vec_ack_o   (vec_ack),
    .out_ready_i (out_ready),
    .out_valid_o (out_valid),
    .out_gidx_o  (out_gidx),
    .out_row_o   (out_row),
    .out_slot_o  (out_slot),
    .out_load_o  (out_load)
  );

  bind gidx_sched_top gidx_sched_chk i_chk (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .vec_req_i   (vec_req_i),
    .vec_ack_o   (vec_ack_o),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_gidx_o  (out_gidx_o),
    .out_row_o   (out_row_o),
    .out_slot_o  (out_slot_o),
    .out_load_o  (out_load_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // LCG step, upper bits give the drawn value
  function automatic int unsigned rand_below(input int unsigned limit);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % limit;
  endfunction

  // Ready is high three cycles out of four on average
  always @(posedge clk) begin
    out_ready <= (rand_below(4) != 0);
  end

  always @(posedge clk) begin
    if (out_valid && out_ready) begin
      seen_gidx.push_back(out_gidx);
      seen_row.push_back(out_row);
      seen_slot.push_back(out_slot);
      seen_load.push_back(out_load);
    end
  end

  task automatic report_counts();
    $display("Checks done: %0d testbench errors, %0d assertion errors",
             err_cnt, i_dut.i_chk.fail_cnt);
  endtask

  task automatic send_vector(input logic [NUM_ROWS-1:0][GID_W-1:0] vec);
    @(posedge clk);
    vec_req  <= 1'b1;
    vec_gidx <= vec;
    do @(posedge clk); while (!vec_ack);
    vec_req <= 1'b0;
    do @(posedge clk); while (vec_ack);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    shadow_valid = '0;
    after_clear  = 1'b1;
  endtask

  task automatic check_vector(input int unsigned idx,
                              input logic [NUM_ROWS-1:0][GID_W-1:0] vec);
    logic [NUM_ROWS-1:0]       rows_seen;
    logic [(1 << GID_W)-1:0]   gidx_started;
    logic                      first;
    logic [GID_W-1:0]          g;
    logic [SLOT_W-1:0]         s;
    rows_seen    = '0;
    gidx_started = '0;
    assert (seen_row.size() == NUM_ROWS) else begin
      err_cnt++;
      $display("FAILED row_count vector %0d: expected %0d, actual %0d",
               idx, NUM_ROWS, seen_row.size());
    end
    for (int k = 0; k < seen_row.size(); k++) begin
      g     = seen_gidx[k];
      s     = seen_slot[k];
      first = (k == 0) || (seen_gidx[k] != seen_gidx[k-1]);
      assert (!rows_seen[seen_row[k]]) else begin
        err_cnt++;
        $display("Row %0d of vector %0d was emitted twice", seen_row[k], idx);
      end
      rows_seen[seen_row[k]] = 1'b1;
      assert (g == vec[seen_row[k]]) else begin
        err_cnt++;
        $display("FAILED row_gidx vector %0d row %0d: expected %0d, actual %0d",
                 idx, seen_row[k], vec[seen_row[k]], g);
      end
      if (first) begin
        // A second start of the same index means the group was split
        assert (!gidx_started[g]) else begin
          err_cnt++;
          $display("Index %0d of vector %0d came out in two separate runs", g, idx);
        end
        gidx_started[g] = 1'b1;
        if (after_clear) begin
          assert (seen_load[k]) else begin
            err_cnt++;
            $display("FAILED load_after_clear vector %0d: expected 1, actual 0", idx);
          end
          after_clear = 1'b0;
        end
        if (seen_load[k]) begin
          shadow_gidx[s]  = g;
          shadow_valid[s] = 1'b1;
        end else begin
          assert (shadow_valid[s] && (shadow_gidx[s] == g)) else begin
            err_cnt++;
            $display("FAILED slot_reuse vector %0d slot %0d: expected %0d, actual %0d",
                     idx, s, shadow_gidx[s], g);
          end
        end
      end else begin
        assert (seen_row[k] > seen_row[k-1]) else begin
          err_cnt++;
          $display("FAILED row_order vector %0d index %0d: expected above %0d, actual %0d",
                   idx, g, seen_row[k-1], seen_row[k]);
        end
        assert (!seen_load[k]) else begin
          err_cnt++;
          $display("FAILED later_row_load vector %0d row %0d: expected 0, actual %0d",
                   idx, seen_row[k], seen_load[k]);
        end
      end
    end
    assert (rows_seen == '1) else begin
      err_cnt++;
      $display("FAILED row_coverage vector %0d: expected %0h, actual %0h",
               idx, {NUM_ROWS{1'b1}}, rows_seen);
    end
    seen_gidx.delete();
    seen_row.delete();
    seen_slot.delete();
    seen_load.delete();
  endtask

  initial begin
    rst_n        <= 1'b0;
    clear        <= 1'b0;
    vec_req      <= 1'b0;
    vec_gidx     <= '0;
    out_ready    <= 1'b0;
    err_cnt      = 0;
    shadow_gidx  = '0;
    shadow_valid = '0;
    after_clear  = 1'b0;
    // Half of the entries come from a narrow range so indices repeat
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        if (rand_below(2) == 0) begin
          vectors[v][r] = GID_W'(rand_below(3));
        end else begin
          vectors[v][r] = GID_W'(rand_below(1 << GID_W));
        end
      end
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int v = 0; v < NUM_VEC; v++) begin
      if (v == CLEAR_VEC) begin
        pulse_clear();
      end
      send_vector(vectors[v]);
      while (out_valid) @(posedge clk);
      check_vector(v, vectors[v]);
    end
    report_counts();
    if ((err_cnt == 0) && (i_dut.i_chk.fail_cnt == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    for (cycle_cnt = 0; cycle_cnt < MAX_CYCLES; cycle_cnt++) begin
      @(posedge clk);
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    report_counts();
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: verilog.f
common/gidx_pkg.sv
verilog/gidx_ctrl.sv
gidx_sched/gidx_lookahead.sv
gidx_sched/gidx_slot_table.sv
gidx_sched/gidx_order_queue.sv
verilog/gidx_sched_top.sv
verification/gidx_sched_chk.sv
verification/gidx_sched_tb.sv

// File: verilog/gidx_ctrl.sv
// Scheduler controller running the four-phase vector handshake and the scan sequence

module gidx_ctrl
  import gidx_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           vec_req_i,
  input  logic [NUM_ROWS-1:0][GID_W-1:0] vec_gidx_i,
  output logic                           vec_ack_o,
  input  scan_res_e                      scan_res_i,
  output logic                           scan_en_o,
  output logic                           scan_start_o,
  output logic [NUM_ROWS-1:0][GID_W-1:0] vec_q_o
);

  ctrl_state_e state_d, state_q;
  logic [NUM_ROWS-1:0][GID_W-1:0] vec_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (vec_req_i) begin
          state_d = SCAN;
        end
      end
      SCAN: begin
        if (scan_res_i == LAST) begin
          state_d = ACK;
        end
      end
      ACK: begin
        // Hold the acknowledge until the caller drops its request
        if (!vec_req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Vector is captured on the same edge that resets the scanner mask
  always_ff @(posedge clk_i) begin
    if (scan_start_o) begin
      vec_q <= vec_gidx_i;
    end
  end

  assign scan_start_o = (state_q == IDLE) && vec_req_i;
  assign scan_en_o    = (state_q == SCAN);
  assign vec_ack_o    = (state_q == ACK);
  assign vec_q_o      = vec_q;

endmodule

// File: verilog/gidx_sched_top.sv
// Group-index scheduler top level joining the controller and the datapath blocks

module gidx_sched_top
  import gidx_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           vec_req_i,
  input  logic [NUM_ROWS-1:0][GID_W-1:0] vec_gidx_i,
  output logic                           vec_ack_o,
  input  logic                           out_ready_i,
  output logic                           out_valid_o,
  output logic [GID_W-1:0]               out_gidx_o,
  output logic [ROW_W-1:0]               out_row_o,
  output logic [SLOT_W-1:0]              out_slot_o,
  output logic                           out_load_o
);

  scan_res_e                       scan_res;
  logic                            scan_en, scan_start;
  logic [NUM_ROWS-1:0][GID_W-1:0]  vec_q;
  logic [NUM_SLOTS-1:0][GID_W-1:0] slot_gidx;
  logic [NUM_SLOTS-1:0]            slot_valid;
  logic                            hit, slot_ok, queue_full;
  logic [SLOT_W-1:0]               slot, row_slot;
  logic                            grp_push, grp_load, row_done;
  logic [GID_W-1:0]                grp_gidx;
  logic [NUM_ROWS-1:0]             grp_mask;

  gidx_ctrl i_ctrl (
    .clk_i, .rst_ni, .clear_i, .vec_req_i, .vec_gidx_i, .vec_ack_o,
    .scan_res_i   (scan_res),
    .scan_en_o    (scan_en),
    .scan_start_o (scan_start),
    .vec_q_o      (vec_q)
  );

  gidx_lookahead i_lookahead (
    .clk_i, .rst_ni, .clear_i,
    .scan_en_i    (scan_en),
    .scan_start_i (scan_start),
    .vec_i        (vec_q),
    .slot_gidx_i  (slot_gidx),
    .slot_valid_i (slot_valid),
    .queue_full_i (queue_full),
    .slot_ok_i    (slot_ok),
    .hit_i        (hit),
    .scan_res_o   (scan_res),
    .grp_push_o   (grp_push),
    .grp_gidx_o   (grp_gidx),
    .grp_mask_o   (grp_mask),
    .grp_load_o   (grp_load)
  );

  gidx_slot_table i_slot_table (
    .clk_i, .rst_ni, .clear_i,
    .cand_gidx_i  (grp_gidx),
    .grp_push_i   (grp_push),
    .grp_mask_i   (grp_mask),
    .row_done_i   (row_done),
    .row_slot_i   (row_slot),
    .slot_gidx_o  (slot_gidx),
    .slot_valid_o (slot_valid),
    .hit_o        (hit),
    .slot_o       (slot),
    .slot_ok_o    (slot_ok)
  );

  gidx_order_queue i_order_queue (
    .clk_i, .rst_ni, .clear_i,
    .grp_push_i   (grp_push),
    .grp_gidx_i   (grp_gidx),
    .grp_mask_i   (grp_mask),
    .grp_load_i   (grp_load),
    .grp_slot_i   (slot),
    .queue_full_o (queue_full),
    .out_ready_i, .out_valid_o, .out_gidx_o, .out_row_o, .out_slot_o, .out_load_o,
    .row_done_o   (row_done),
    .row_slot_o   (row_slot)
  );

endmodule
